//--- bench/bridge_stim.txt
# kind port uncached addr pattern, port is i, d or id, word k carries pattern + k
# id reads both caches at once, the data cache at addr + 100 with pattern + 01000000
read i 0 00001000 10000000
read d 1 00002004 20000000
read id 0 00003000 30000000
write d 0 00004000 40000000
write d 1 00005008 50000000
read d 0 00006040 60000000
write d 0 00007000 70000000
read i 0 00008000 80000000
write d 1 0000900c 90000000
read id 1 0000a000 a0000000
read d 1 0000b004 b0000000
write d 0 0000c000 c0000000
read i 0 0000d000 d0000000
read d 0 0000e000 e0000000
write d 1 0000f001 f0000000
read id 0 00010000 11000000
write d 0 00011000 12000000
read i 0 00012000 13000000

//--- flist.f
common/axi_pkg.sv
common/bridge_pkg.sv
read/read_arbiter.sv
read/read_engine.sv
write/line_buffer.sv
write/write_engine.sv
source/axi_sram_bridge.sv
bench/tb_axi_sram_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_sram_bridge
FLIST     ?= flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

//--- bench/tb_axi_sram_bridge.sv
`timescale 1ns/1ps

module tb_axi_sram_bridge
	import axi_pkg::*, bridge_pkg::*;
();

	localparam int wait_limit = 2000;  // cycles per wait

	typedef struct packed {
		logic [axi_id_w-1:0]    id;
		logic [axi_addr_w-1:0]  addr;
		logic [axi_data_w-1:0]  pat;   // word k carries pat + k
		logic [axi_len_w-1:0]   len;
		logic [axi_burst_w-1:0] burst;
		logic [axi_strb_w-1:0]  strb;
	} xfer_t;

	logic                   aclk = 1'b0;
	logic                   aresetn = 1'b0;
	logic                   conf_sel = 1'b0;
	logic                   icache_rd_req = 1'b0;
	logic [axi_addr_w-1:0]  icache_rd_addr = '0;
	logic [axi_size_w-1:0]  icache_rd_type = '0;
	logic                   icache_rd_rdy;
	logic                   icache_ret_valid;
	logic                   icache_ret_last;
	logic [axi_data_w-1:0]  icache_ret_data;
	logic                   dcache_rd_req = 1'b0;
	logic [axi_addr_w-1:0]  dcache_rd_addr = '0;
	logic [axi_size_w-1:0]  dcache_rd_type = '0;
	logic                   dcache_rd_rdy;
	logic                   dcache_ret_valid;
	logic                   dcache_ret_last;
	logic [axi_data_w-1:0]  dcache_ret_data;
	logic                   dcache_wr_req = 1'b0;
	logic [axi_addr_w-1:0]  dcache_wr_addr = '0;
	logic [axi_size_w-1:0]  dcache_wr_type = '0;
	logic [axi_strb_w-1:0]  dcache_wr_wstrb = '0;
	logic [line_w-1:0]      dcache_wr_data = '0;
	logic [axi_data_w-1:0]  uncache_wr_data = '0;
	logic                   dcache_wr_rdy;
	logic [axi_id_w-1:0]    arid;
	logic [axi_addr_w-1:0]  araddr;
	logic [axi_len_w-1:0]   arlen;
	logic [axi_size_w-1:0]  arsize;
	logic [axi_burst_w-1:0] arburst;
	logic                   arvalid;
	logic                   arready = 1'b0;
	logic [axi_id_w-1:0]    rid = '0;
	logic [axi_data_w-1:0]  rdata = '0;
	logic [1:0]             rresp = 2'b00;
	logic                   rlast = 1'b0;
	logic                   rvalid = 1'b0;
	logic                   rready;
	logic [axi_addr_w-1:0]  awaddr;
	logic [axi_len_w-1:0]   awlen;
	logic [axi_size_w-1:0]  awsize;
	logic [axi_burst_w-1:0] awburst;
	logic                   awvalid;
	logic                   awready = 1'b0;
	logic [axi_data_w-1:0]  wdata;
	logic [axi_strb_w-1:0]  wstrb;
	logic                   wlast;
	logic                   wvalid;
	logic                   wready = 1'b0;
	logic [1:0]             bresp = 2'b00;
	logic                   bvalid = 1'b0;
	logic                   bready;

	// expected transfers in AR and AW order
	xfer_t rd_q[$];
	xfer_t wr_q[$];
	xfer_t cur_rd = '0;
	xfer_t cur_wr = '0;
	int    rd_ptr = 0;
	int    wr_ptr = 0;
	int    rd_issued = 0;
	int    rd_done_cnt = 0;
	int    wr_issued = 0;
	int    wr_done_cnt = 0;
	logic [axi_len_w-1:0] rd_beat = '0;
	logic [axi_len_w-1:0] w_beat = '0;

	// slave model state
	integer                seed = 79;
	logic                  r_busy = 1'b0;
	logic                  b_due = 1'b0;
	logic                  go;
	logic [axi_len_w-1:0]  r_k = '0;
	logic [axi_len_w-1:0]  r_n = '0;
	logic [axi_len_w-1:0]  nk;
	logic [axi_data_w-1:0] r_base = '0;

	// stimulus file fields
	int             fd;
	int             n;
	int             t;
	int             unc_i;
	logic           done;
	logic [63:0]    kind_s;
	logic [63:0]    port_s;
	logic [31:0]    addr_v;
	logic [31:0]    pat_v;
	logic [8*96-1:0] line_buf;

	axi_sram_bridge axi_sram_bridge_inst (.*);

	initial begin
		forever #10 aclk = ~aclk;
	end

	task automatic abort_run(input string what);
		$display("ERROR: %s", what);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	function automatic logic ready_of(input int which);
		case (which)
			0: return icache_rd_rdy;
			1: return dcache_rd_rdy;
			default: return dcache_wr_rdy;
		endcase
	endfunction

	// returns on the edge where the request is taken
	task automatic wait_ready(input int which, input string what);
		int cnt;
		cnt = 0;
		@(negedge aclk);
		while (!ready_of(which)) begin
			cnt = cnt + 1;
			if (cnt > wait_limit)
				abort_run({"timeout, ", what, " was never accepted"});
			else
				@(negedge aclk);
		end
		@(posedge aclk);
	endtask

	task automatic issue_read(input logic use_i, input logic use_d, input logic unc,
			input logic [31:0] addr, input logic [31:0] pat);
		xfer_t rec;
		logic  both;
		both = use_i && use_d;
		@(posedge aclk);
		conf_sel       <= unc;
		icache_rd_req  <= use_i;
		icache_rd_addr <= addr;
		icache_rd_type <= 3'd2;
		dcache_rd_req  <= use_d;
		dcache_rd_addr <= both ? addr + 32'h100 : addr;
		dcache_rd_type <= 3'd2;
		if (use_i) begin
			wait_ready(0, "instruction cache read request");
			icache_rd_req <= 1'b0;
			rec = '{id_icache, addr, pat, len_line, burst_incr, 4'h0};
			rd_q.push_back(rec);
			rd_issued++;
		end
		if (use_d) begin
			wait_ready(1, "data cache read request");
			dcache_rd_req <= 1'b0;
			rec.id    = id_dcache;
			rec.addr  = both ? addr + 32'h100 : addr;
			rec.pat   = both ? pat + 32'h0100_0000 : pat;
			rec.len   = unc ? len_single : len_line;
			rec.burst = unc ? burst_fixed : burst_incr;
			rec.strb  = 4'h0;
			rd_q.push_back(rec);
			rd_issued++;
		end
	endtask

	task automatic issue_write(input logic unc, input logic [31:0] addr, input logic [31:0] pat);
		xfer_t             rec;
		logic [line_w-1:0] line_v;
		// the source not written carries inverted data
		for (int k = 0; k < line_beats; k++)
			line_v[k*axi_data_w +: axi_data_w] = unc ? ~(pat + 32'(k)) : pat + 32'(k);
		rec.id    = write_id;
		rec.addr  = addr;
		rec.pat   = pat;
		rec.len   = unc ? len_single : len_line;
		rec.burst = unc ? burst_fixed : burst_incr;
		rec.strb  = unc ? (4'b0001 << addr[1:0]) : 4'hf;  // byte lane of the word
		@(posedge aclk);
		conf_sel        <= unc;
		dcache_wr_req   <= 1'b1;
		dcache_wr_addr  <= addr;
		dcache_wr_type  <= 3'd2;
		dcache_wr_wstrb <= rec.strb;
		dcache_wr_data  <= line_v;
		uncache_wr_data <= unc ? pat : ~pat;
		wait_ready(2, "data cache write request");
		dcache_wr_req <= 1'b0;
		wr_q.push_back(rec);
		wr_issued++;
	endtask

	// AXI slave model with random ready and valid gaps
	always @(posedge aclk) begin
		if (!aresetn) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			r_busy  <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			b_due   <= 1'b0;
		end else begin
			arready <= (($random(seed) & 3) != 0);
			awready <= (($random(seed) & 3) != 0);
			wready  <= (($random(seed) & 3) != 0);
			if (arvalid && arready) begin
				r_busy <= 1'b1;
				r_k    <= '0;
				r_n    <= arlen;
				rid    <= arid;
				r_base <= cur_rd.pat;  // picked up by the monitor at the AR beat
			end
			if (r_busy && (!rvalid || rready)) begin
				nk = rvalid ? r_k + 4'd1 : r_k;
				if (rvalid && rlast) begin
					r_busy <= 1'b0;
					rvalid <= 1'b0;
				end else begin
					go = (($random(seed) & 1) != 0);
					r_k    <= nk;
					rvalid <= go;
					rdata  <= r_base + 32'(nk);
					rlast  <= (nk == r_n);
				end
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				b_due  <= 1'b0;
			end else if (b_due && !bvalid) begin
				bvalid <= (($random(seed) & 1) != 0);
			end
			if (wvalid && wready && wlast)
				b_due <= 1'b1;
		end
	end

	// bus monitor on the falling edge
	always @(negedge aclk) begin
		if (aresetn) begin
			if (icache_rd_req)
				check_value("dcache_rd_rdy", 32'(dcache_rd_rdy), 32'd0);
			if (arvalid && arready) begin
				if (rd_ptr >= rd_q.size()) begin
					abort_run("AR was issued without an accepted read request");
				end else begin
					cur_rd = rd_q[rd_ptr];
					rd_ptr++;
					rd_beat = '0;
					check_value("arid", 32'(arid), 32'(cur_rd.id));
					check_value("araddr", araddr, cur_rd.addr);
					check_value("arlen", 32'(arlen), 32'(cur_rd.len));
					check_value("arsize", 32'(arsize), 32'd2);
					check_value("arburst", 32'(arburst), 32'(cur_rd.burst));
				end
			end
			check_value("icache_ret_valid", 32'(icache_ret_valid),
				32'(rvalid && rready && cur_rd.id == id_icache));
			check_value("dcache_ret_valid", 32'(dcache_ret_valid),
				32'(rvalid && rready && cur_rd.id == id_dcache));
			if (rvalid && rready) begin
				if (cur_rd.id == id_icache) begin
					check_value("icache_ret_data", icache_ret_data, cur_rd.pat + 32'(rd_beat));
					check_value("icache_ret_last", 32'(icache_ret_last),
						32'(rd_beat == cur_rd.len));
				end else begin
					check_value("dcache_ret_data", dcache_ret_data, cur_rd.pat + 32'(rd_beat));
					check_value("dcache_ret_last", 32'(dcache_ret_last),
						32'(rd_beat == cur_rd.len));
				end
				rd_beat++;
				if (rlast)
					rd_done_cnt++;
			end
			if (wr_issued != wr_done_cnt)
				check_value("dcache_wr_rdy", 32'(dcache_wr_rdy), 32'd0);  // busy until after B
			if (awvalid && awready) begin
				if (wr_ptr >= wr_q.size()) begin
					abort_run("AW was issued without an accepted write request");
				end else begin
					cur_wr = wr_q[wr_ptr];
					wr_ptr++;
					w_beat = '0;
					check_value("awaddr", awaddr, cur_wr.addr);
					check_value("awlen", 32'(awlen), 32'(cur_wr.len));
					check_value("awsize", 32'(awsize), 32'd2);
					check_value("awburst", 32'(awburst), 32'(cur_wr.burst));
				end
			end
			if (wvalid && wready) begin
				check_value("wdata", wdata, cur_wr.pat + 32'(w_beat));
				check_value("wstrb", 32'(wstrb), 32'(cur_wr.strb));
				check_value("wlast", 32'(wlast), 32'(w_beat == cur_wr.len));
				w_beat++;
			end
			if (bvalid && bready)
				wr_done_cnt++;
		end
	end

	initial begin
		fd = $fopen("bench/bridge_stim.txt", "r");
		if (fd == 0)
			abort_run("cannot open the stimulus file bench/bridge_stim.txt");
		repeat (2) @(posedge aclk);
		aresetn <= 1'b1;
		@(negedge aclk);
		check_value("arvalid", 32'(arvalid), 32'd0);
		check_value("rready", 32'(rready), 32'd0);
		check_value("awvalid", 32'(awvalid), 32'd0);
		check_value("wvalid", 32'(wvalid), 32'd0);
		check_value("bready", 32'(bready), 32'd0);
		check_value("icache_ret_valid", 32'(icache_ret_valid), 32'd0);
		check_value("dcache_ret_valid", 32'(dcache_ret_valid), 32'd0);
		check_value("icache_rd_rdy", 32'(icache_rd_rdy), 32'd1);
		check_value("dcache_rd_rdy", 32'(dcache_rd_rdy), 32'd1);
		check_value("dcache_wr_rdy", 32'(dcache_wr_rdy), 32'd1);
		done = 1'b0;
		while (!done) begin
			kind_s = '0;
			port_s = '0;
			n = $fscanf(fd, " %s", kind_s);
			if (n != 1) begin
				done = 1'b1;
			end else if (kind_s == 64'("#")) begin
				n = $fgets(line_buf, fd);  // comment line
			end else begin
				n = $fscanf(fd, " %s %d %h %h", port_s, unc_i, addr_v, pat_v);
				if (n != 4)
					abort_run("malformed line in the stimulus file");
				else if (kind_s == 64'("read"))
					issue_read(port_s == 64'("i") || port_s == 64'("id"),
						port_s == 64'("d") || port_s == 64'("id"), unc_i != 0, addr_v, pat_v);
				else if (kind_s == 64'("write"))
					issue_write(unc_i != 0, addr_v, pat_v);
				else
					abort_run("unknown transaction kind in the stimulus file");
			end
		end
		$fclose(fd);
		t = 0;
		while (rd_done_cnt != rd_issued || wr_done_cnt != wr_issued) begin
			t = t + 1;
			if (t > wait_limit)
				abort_run("timeout, outstanding reads or writes never completed");
			else
				@(negedge aclk);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

//--- source/axi_sram_bridge.sv
`timescale 1ns/1ps

module axi_sram_bridge import axi_pkg::*, bridge_pkg::*; (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic                   conf_sel,
	// instruction cache
	input  logic                   icache_rd_req,
	input  logic [axi_addr_w-1:0]  icache_rd_addr,
	input  logic [axi_size_w-1:0]  icache_rd_type,
	output logic                   icache_rd_rdy,
	output logic                   icache_ret_valid,
	output logic                   icache_ret_last,
	output logic [axi_data_w-1:0]  icache_ret_data,
	// data cache reads
	input  logic                   dcache_rd_req,
	input  logic [axi_addr_w-1:0]  dcache_rd_addr,
	input  logic [axi_size_w-1:0]  dcache_rd_type,
	output logic                   dcache_rd_rdy,
	output logic                   dcache_ret_valid,
	output logic                   dcache_ret_last,
	output logic [axi_data_w-1:0]  dcache_ret_data,
	// data cache writes
	input  logic                   dcache_wr_req,
	input  logic [axi_addr_w-1:0]  dcache_wr_addr,
	input  logic [axi_size_w-1:0]  dcache_wr_type,
	input  logic [axi_strb_w-1:0]  dcache_wr_wstrb,
	input  logic [line_w-1:0]      dcache_wr_data,
	input  logic [axi_data_w-1:0]  uncache_wr_data,
	output logic                   dcache_wr_rdy,
	// AR
	output logic [axi_id_w-1:0]    arid,
	output logic [axi_addr_w-1:0]  araddr,
	output logic [axi_len_w-1:0]   arlen,
	output logic [axi_size_w-1:0]  arsize,
	output logic [axi_burst_w-1:0] arburst,
	output logic                   arvalid,
	input  logic                   arready,
	// R
	input  logic [axi_id_w-1:0]    rid,
	input  logic [axi_data_w-1:0]  rdata,
	input  logic [1:0]             rresp,
	input  logic                   rlast,
	input  logic                   rvalid,
	output logic                   rready,
	// AW
	output logic [axi_addr_w-1:0]  awaddr,
	output logic [axi_len_w-1:0]   awlen,
	output logic [axi_size_w-1:0]  awsize,
	output logic [axi_burst_w-1:0] awburst,
	output logic                   awvalid,
	input  logic                   awready,
	// W
	output logic [axi_data_w-1:0]  wdata,
	output logic [axi_strb_w-1:0]  wstrb,
	output logic                   wlast,
	output logic                   wvalid,
	input  logic                   wready,
	// B
	input  logic [1:0]             bresp,
	input  logic                   bvalid,
	output logic                   bready
);

	// held read request, arbiter to engine
	logic                   rd_pending;
	logic [axi_addr_w-1:0]  rd_addr;
	logic [axi_size_w-1:0]  rd_size;
	logic [axi_len_w-1:0]   rd_len;
	logic [axi_burst_w-1:0] rd_burst;
	logic [axi_id_w-1:0]    rd_id;
	logic                   rd_done;

	read_arbiter read_arbiter_inst (
		.aclk           (aclk),
		.aresetn        (aresetn),
		.conf_sel       (conf_sel),
		.icache_rd_req  (icache_rd_req),
		.icache_rd_addr (icache_rd_addr),
		.icache_rd_type (icache_rd_type),
		.dcache_rd_req  (dcache_rd_req),
		.dcache_rd_addr (dcache_rd_addr),
		.dcache_rd_type (dcache_rd_type),
		.icache_rd_rdy  (icache_rd_rdy),
		.dcache_rd_rdy  (dcache_rd_rdy),
		.rd_done        (rd_done),
		.rd_pending     (rd_pending),
		.rd_addr        (rd_addr),
		.rd_size        (rd_size),
		.rd_len         (rd_len),
		.rd_burst       (rd_burst),
		.rd_id          (rd_id)
	);

	read_engine read_engine_inst (
		.aclk             (aclk),
		.aresetn          (aresetn),
		.rd_pending       (rd_pending),
		.rd_addr          (rd_addr),
		.rd_size          (rd_size),
		.rd_len           (rd_len),
		.rd_burst         (rd_burst),
		.rd_id            (rd_id),
		.rd_done          (rd_done),
		.arid             (arid),
		.araddr           (araddr),
		.arlen            (arlen),
		.arsize           (arsize),
		.arburst          (arburst),
		.arvalid          (arvalid),
		.arready          (arready),
		.rid              (rid),
		.rdata            (rdata),
		.rresp            (rresp),
		.rlast            (rlast),
		.rvalid           (rvalid),
		.rready           (rready),
		.icache_ret_valid (icache_ret_valid),
		.icache_ret_last  (icache_ret_last),
		.icache_ret_data  (icache_ret_data),
		.dcache_ret_valid (dcache_ret_valid),
		.dcache_ret_last  (dcache_ret_last),
		.dcache_ret_data  (dcache_ret_data)
	);

	write_engine write_engine_inst (
		.aclk            (aclk),
		.aresetn         (aresetn),
		.conf_sel        (conf_sel),
		.dcache_wr_req   (dcache_wr_req),
		.dcache_wr_addr  (dcache_wr_addr),
		.dcache_wr_type  (dcache_wr_type),
		.dcache_wr_wstrb (dcache_wr_wstrb),
		.dcache_wr_data  (dcache_wr_data),
		.uncache_wr_data (uncache_wr_data),
		.dcache_wr_rdy   (dcache_wr_rdy),
		.awaddr          (awaddr),
		.awlen           (awlen),
		.awsize          (awsize),
		.awburst         (awburst),
		.awvalid         (awvalid),
		.awready         (awready),
		.wdata           (wdata),
		.wstrb           (wstrb),
		.wlast           (wlast),
		.wvalid          (wvalid),
		.wready          (wready),
		.bresp           (bresp),
		.bvalid          (bvalid),
		.bready          (bready)
	);

endmodule

//--- write/write_engine.sv
`timescale 1ns/1ps

module write_engine import axi_pkg::*, bridge_pkg::*; (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic                   conf_sel,
	input  logic                   dcache_wr_req,
	input  logic [axi_addr_w-1:0]  dcache_wr_addr,
	input  logic [axi_size_w-1:0]  dcache_wr_type,
	input  logic [axi_strb_w-1:0]  dcache_wr_wstrb,
	input  logic [line_w-1:0]      dcache_wr_data,
	input  logic [axi_data_w-1:0]  uncache_wr_data,
	output logic                   dcache_wr_rdy,
	output logic [axi_addr_w-1:0]  awaddr,
	output logic [axi_len_w-1:0]   awlen,
	output logic [axi_size_w-1:0]  awsize,
	output logic [axi_burst_w-1:0] awburst,
	output logic                   awvalid,
	input  logic                   awready,
	output logic [axi_data_w-1:0]  wdata,
	output logic [axi_strb_w-1:0]  wstrb,
	output logic                   wlast,
	output logic                   wvalid,
	input  logic                   wready,
	input  logic [1:0]             bresp,
	input  logic                   bvalid,
	output logic                   bready
);

	wr_state_t state;
	logic      take;
	logic      w_beat;
	logic      uncached_q;  // single-beat FIXED write

	assign dcache_wr_rdy = (state == wr_st_idle);
	assign take          = dcache_wr_req && dcache_wr_rdy;
	assign w_beat        = wvalid && wready;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= wr_st_idle;
		end else begin
			case (state)
				wr_st_idle:
					if (take)
						state <= wr_st_addr;
				wr_st_addr:
					if (awready)
						state <= wr_st_data;
				wr_st_data:
					if (w_beat && wlast)
						state <= wr_st_resp;
				wr_st_resp:
					if (bvalid)
						state <= wr_st_idle;  // rdy back one cycle after B
				default:
					state <= wr_st_idle;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (take) begin
			awaddr     <= dcache_wr_addr;
			awsize     <= dcache_wr_type;
			wstrb      <= dcache_wr_wstrb;
			uncached_q <= conf_sel;
		end
	end

	assign awvalid = (state == wr_st_addr);
	assign awlen   = uncached_q ? len_single : len_line;
	assign awburst = uncached_q ? burst_fixed : burst_incr;
	assign wvalid  = (state == wr_st_data);
	assign bready  = (state == wr_st_resp);

	line_buffer line_buffer_inst (
		.aclk     (aclk),
		.aresetn  (aresetn),
		.load     (take),
		.shift    (w_beat),
		.uncached (conf_sel),
		.line     (dcache_wr_data),
		.word     (uncache_wr_data),
		.data     (wdata),
		.last     (wlast)
	);

endmodule

//--- write/line_buffer.sv
`timescale 1ns/1ps

module line_buffer import axi_pkg::*, bridge_pkg::*; (
	input  logic                  aclk,
	input  logic                  aresetn,
	input  logic                  load,
	input  logic                  shift,
	input  logic                  uncached,  // sampled on load
	input  logic [line_w-1:0]     line,
	input  logic [axi_data_w-1:0] word,
	output logic [axi_data_w-1:0] data,
	output logic                  last
);

	logic [line_w-1:0]     buf_q;
	logic [beat_cnt_w-1:0] beat_cnt;
	logic                  single;

	// lowest word goes out first
	always_ff @(posedge aclk) begin
		if (load)
			buf_q <= uncached ? {{(line_w - axi_data_w){1'b0}}, word} : line;
		else if (shift)
			buf_q <= {{axi_data_w{1'b0}}, buf_q[line_w-1:axi_data_w]};
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			beat_cnt <= '0;
			single   <= 1'b0;
		end else if (load) begin
			beat_cnt <= '0;
			single   <= uncached;
		end else if (shift) begin
			beat_cnt <= beat_cnt + 1'b1;  // wraps after beat 16
		end
	end

	assign data = buf_q[axi_data_w-1:0];
	assign last = single || (beat_cnt == beat_cnt_w'(line_beats - 1));

endmodule

//--- read/read_engine.sv
`timescale 1ns/1ps

module read_engine import axi_pkg::*, bridge_pkg::*; (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic                   rd_pending,
	input  logic [axi_addr_w-1:0]  rd_addr,
	input  logic [axi_size_w-1:0]  rd_size,
	input  logic [axi_len_w-1:0]   rd_len,
	input  logic [axi_burst_w-1:0] rd_burst,
	input  logic [axi_id_w-1:0]    rd_id,
	output logic                   rd_done,
	output logic [axi_id_w-1:0]    arid,
	output logic [axi_addr_w-1:0]  araddr,
	output logic [axi_len_w-1:0]   arlen,
	output logic [axi_size_w-1:0]  arsize,
	output logic [axi_burst_w-1:0] arburst,
	output logic                   arvalid,
	input  logic                   arready,
	input  logic [axi_id_w-1:0]    rid,
	input  logic [axi_data_w-1:0]  rdata,
	input  logic [1:0]             rresp,
	input  logic                   rlast,
	input  logic                   rvalid,
	output logic                   rready,
	output logic                   icache_ret_valid,
	output logic                   icache_ret_last,
	output logic [axi_data_w-1:0]  icache_ret_data,
	output logic                   dcache_ret_valid,
	output logic                   dcache_ret_last,
	output logic [axi_data_w-1:0]  dcache_ret_data
);

	rd_state_t state;
	logic      beat;
	logic      to_icache;
	logic      to_dcache;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= rd_st_idle;
		end else begin
			case (state)
				rd_st_idle:
					if (rd_pending)
						state <= arready ? rd_st_data : rd_st_addr;
				rd_st_addr:
					if (arready)
						state <= rd_st_data;
				rd_st_data:
					if (rd_done)
						state <= rd_st_idle;
				default:
					state <= rd_st_idle;
			endcase
		end
	end

	// AR goes out the cycle after the cache handshake
	assign arvalid = (state == rd_st_idle && rd_pending) || state == rd_st_addr;
	assign arid    = rd_id;
	assign araddr  = rd_addr;
	assign arlen   = rd_len;
	assign arsize  = rd_size;
	assign arburst = rd_burst;

	assign rready  = (state == rd_st_data);
	assign beat    = rvalid && rready;
	assign rd_done = beat && rlast;

	// steer each beat by rid
	assign to_icache = beat && (rid == id_icache);
	assign to_dcache = beat && (rid == id_dcache);

	assign icache_ret_valid = to_icache;
	assign icache_ret_last  = to_icache && rlast;
	assign icache_ret_data  = rdata;
	assign dcache_ret_valid = to_dcache;
	assign dcache_ret_last  = to_dcache && rlast;
	assign dcache_ret_data  = rdata;

endmodule

//--- read/read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter import axi_pkg::*; (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic                   conf_sel,
	input  logic                   icache_rd_req,
	input  logic [axi_addr_w-1:0]  icache_rd_addr,
	input  logic [axi_size_w-1:0]  icache_rd_type,
	input  logic                   dcache_rd_req,
	input  logic [axi_addr_w-1:0]  dcache_rd_addr,
	input  logic [axi_size_w-1:0]  dcache_rd_type,
	output logic                   icache_rd_rdy,
	output logic                   dcache_rd_rdy,
	input  logic                   rd_done,
	output logic                   rd_pending,
	output logic [axi_addr_w-1:0]  rd_addr,
	output logic [axi_size_w-1:0]  rd_size,
	output logic [axi_len_w-1:0]   rd_len,
	output logic [axi_burst_w-1:0] rd_burst,
	output logic [axi_id_w-1:0]    rd_id
);

	logic take_i;
	logic take_d;

	// icache has priority whenever the slot is free
	assign icache_rd_rdy = !rd_pending;
	assign dcache_rd_rdy = !rd_pending && !icache_rd_req;

	assign take_i = icache_rd_req && icache_rd_rdy;
	assign take_d = dcache_rd_req && dcache_rd_rdy;

	always_ff @(posedge aclk) begin
		if (!aresetn)
			rd_pending <= 1'b0;
		else if (rd_done)
			rd_pending <= 1'b0;  // last beat gone, slot free next cycle
		else if (take_i || take_d)
			rd_pending <= 1'b1;
	end

	always_ff @(posedge aclk) begin
		if (take_i) begin
			rd_addr  <= icache_rd_addr;
			rd_size  <= icache_rd_type;
			rd_id    <= id_icache;
			rd_len   <= len_line;
			rd_burst <= burst_incr;
		end else if (take_d) begin
			rd_addr  <= dcache_rd_addr;
			rd_size  <= dcache_rd_type;
			rd_id    <= id_dcache;
			// uncached loads fetch one word only
			rd_len   <= conf_sel ? len_single : len_line;
			rd_burst <= conf_sel ? burst_fixed : burst_incr;
		end
	end

endmodule

//--- common/bridge_pkg.sv
package bridge_pkg;

	// cache side
	localparam int line_w     = 512;
	localparam int line_beats = 16;  // 32-bit words per line
	localparam int beat_cnt_w = 4;

	// read engine
	typedef enum logic [1:0] {
		rd_st_idle,
		rd_st_addr,  // AR waiting for arready
		rd_st_data
	} rd_state_t;

	// write engine
	typedef enum logic [1:0] {
		wr_st_idle,
		wr_st_addr,
		wr_st_data,
		wr_st_resp  // waiting for B
	} wr_state_t;

endpackage

//--- common/axi_pkg.sv
package axi_pkg;

	// bus widths
	localparam int axi_addr_w  = 32;
	localparam int axi_data_w  = 32;
	localparam int axi_strb_w  = 4;
	localparam int axi_id_w    = 4;
	localparam int axi_len_w   = 4;
	localparam int axi_size_w  = 3;
	localparam int axi_burst_w = 2;

	// burst type codes
	localparam logic [axi_burst_w-1:0] burst_fixed = 2'b00;
	localparam logic [axi_burst_w-1:0] burst_incr  = 2'b01;

	// arlen/awlen, beats minus one
	localparam logic [axi_len_w-1:0] len_line   = 4'd15;  // full cache line
	localparam logic [axi_len_w-1:0] len_single = 4'd0;

	// transaction ids
	localparam logic [axi_id_w-1:0] id_icache = 4'd0;
	localparam logic [axi_id_w-1:0] id_dcache = 4'd1;
	localparam logic [axi_id_w-1:0] write_id  = 4'd1;  // awid as tied off outside

endpackage
